// File: verilog/cpuPkg.sv
/* Widths, RV32I encodings and ALU operations for the four-stage core.
   Only the word-sized load and store of the kept subset are encoded here. */
package cpuPkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word;
  typedef logic [4:0]      regId;
  typedef logic [31:0]     instWord;

  // ALU operations where aluEq and aluNe return 1 or 0 for branches
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluPassB,
    aluEq,
    aluNe
  } aluOp;

  localparam word resetPc = 32'h0000_0000;

  // data memory depth in words and its index width
  localparam int dmemWords = 256;
  localparam int dmemIdxW  = $clog2(dmemWords);

  // major opcodes
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opSystem = 7'b1110011;

  // funct3 values
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Beq    = 3'b000;
  localparam logic [2:0] f3Bne    = 3'b001;
  localparam logic [2:0] f3Word   = 3'b010;

  // funct7 of plain and alternate (sub) register ops
  localparam logic [6:0] f7Base = 7'b0000000;
  localparam logic [6:0] f7Alt  = 7'b0100000;

  localparam instWord instEbreak = 32'h0010_0073;

endpackage

// File: verilog/pipeBus.sv
/* Execute result and writeback buses. Both carry plain levels with no
   handshake; the writeback enables are already gated by the stage valid. */
interface exResultIf;
  logic valid;
  cpuPkg::regId rd;
  logic regWen;
  logic memWen;
  logic isLoad;
  logic isLink;
  logic halt;
  logic illegal;
  cpuPkg::word aluResult;
  cpuPkg::word storeData;
  cpuPkg::word linkAddr;
  cpuPkg::word pc;

  modport producer (output valid, rd, regWen, memWen, isLoad, isLink, halt, illegal,
                    aluResult, storeData, linkAddr, pc);
  modport consumer (input valid, rd, regWen, memWen, isLoad, isLink, halt, illegal,
                    aluResult, storeData, linkAddr, pc);
endinterface

interface writebackIf;
  logic retire;
  logic regWen;
  cpuPkg::regId rd;
  cpuPkg::word wdata;
  cpuPkg::word pc;
  logic halt;
  logic illegal;

  modport source (output retire, regWen, rd, wdata, pc, halt, illegal);
  modport sink (input retire, regWen, rd, wdata, pc, halt, illegal);
endinterface

// File: verilog/decoder.sv
/* Decoder for the kept RV32I subset. Anything outside it, ecall included,
   comes out as illegal plus halt with every write enable cleared. */
module decoder (
  input  cpuPkg::instWord inst,
  output cpuPkg::regId    rd,
  output cpuPkg::regId    rs1,
  output cpuPkg::regId    rs2,
  output cpuPkg::word     imm,
  output cpuPkg::aluOp    aluSel,
  output logic useImm,
  output logic regWen,
  output logic memWen,
  output logic isLoad,
  output logic isBranch,
  output logic isJal,
  output logic isJalr,
  output logic isLink,
  output logic halt,
  output logic illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  cpuPkg::word immI;
  cpuPkg::word immS;
  cpuPkg::word immB;
  cpuPkg::word immU;
  cpuPkg::word immJ;
  logic bad;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm = '0;
    aluSel = cpuPkg::aluAdd;
    useImm = 1'b0;
    regWen = 1'b0;
    memWen = 1'b0;
    isLoad = 1'b0;
    isBranch = 1'b0;
    isJal = 1'b0;
    isJalr = 1'b0;
    bad = 1'b0;
    unique case (opcode)
      cpuPkg::opOp: begin
        regWen = 1'b1;
        case ({funct7, funct3})
          {cpuPkg::f7Base, cpuPkg::f3AddSub}: aluSel = cpuPkg::aluAdd;
          {cpuPkg::f7Alt, cpuPkg::f3AddSub}:  aluSel = cpuPkg::aluSub;
          {cpuPkg::f7Base, cpuPkg::f3Slt}:    aluSel = cpuPkg::aluSlt;
          {cpuPkg::f7Base, cpuPkg::f3Xor}:    aluSel = cpuPkg::aluXor;
          {cpuPkg::f7Base, cpuPkg::f3Or}:     aluSel = cpuPkg::aluOr;
          {cpuPkg::f7Base, cpuPkg::f3And}:    aluSel = cpuPkg::aluAnd;
          default: bad = 1'b1;
        endcase
      end
      // only addi among the immediate ops
      cpuPkg::opImm: begin
        {useImm, regWen, imm} = {2'b11, immI};
        bad = (funct3 != cpuPkg::f3AddSub);
      end
      cpuPkg::opLui: begin
        {useImm, regWen, imm} = {2'b11, immU};
        aluSel = cpuPkg::aluPassB;
      end
      cpuPkg::opLoad: begin
        {useImm, regWen, isLoad, imm} = {3'b111, immI};
        bad = (funct3 != cpuPkg::f3Word);
      end
      cpuPkg::opStore: begin
        {useImm, memWen, imm} = {2'b11, immS};
        bad = (funct3 != cpuPkg::f3Word);
      end
      cpuPkg::opBranch: begin
        isBranch = 1'b1;
        imm = immB;
        if (funct3 == cpuPkg::f3Beq) aluSel = cpuPkg::aluEq;
        else if (funct3 == cpuPkg::f3Bne) aluSel = cpuPkg::aluNe;
        else bad = 1'b1;
      end
      cpuPkg::opJal: {isJal, regWen, imm} = {2'b11, immJ};
      cpuPkg::opJalr: begin
        {isJalr, useImm, regWen, imm} = {3'b111, immI};
        bad = (funct3 != 3'b000);
      end
      cpuPkg::opSystem: bad = (inst != cpuPkg::instEbreak);
      default: bad = 1'b1;
    endcase
    if (bad) begin
      {regWen, memWen, isLoad, isBranch, isJal, isJalr} = '0;
    end
    // x0 is never written
    if (rd == '0) regWen = 1'b0;
  end

  assign isLink  = isJal | isJalr;
  assign illegal = bad;
  assign halt    = bad | (opcode == cpuPkg::opSystem);

endmodule

// File: verilog/regFile.sv
/* 31 stored registers with x0 tied to zero. Reads see a same-cycle write,
   so decode never waits on writeback. */
module regFile (
  input  logic clk,
  input  cpuPkg::regId rs1,
  input  cpuPkg::regId rs2,
  output cpuPkg::word  rdata1,
  output cpuPkg::word  rdata2,
  writebackIf.sink     wb
);

  cpuPkg::word regs [1:31];

  function automatic cpuPkg::word readPort(cpuPkg::regId idx);
    if (idx == '0) return '0;
    // write-through from the memory stage
    if (wb.regWen && wb.rd == idx) return wb.wdata;
    return regs[idx];
  endfunction

  always_comb begin
    rdata1 = readPort(rs1);
    rdata2 = readPort(rs2);
  end

  always_ff @(posedge clk) begin
    if (wb.regWen && wb.rd != '0) regs[wb.rd] <= wb.wdata;
  end

endmodule

// File: verilog/executeUnit.sv
/* Execute stage, purely combinational. Only the memory stage is forwarded;
   the stage two ahead reaches decode through the register file. */
module executeUnit (
  input  logic valid,
  input  cpuPkg::word  pc,
  input  cpuPkg::word  imm,
  input  cpuPkg::word  rdata1,
  input  cpuPkg::word  rdata2,
  input  cpuPkg::regId rs1,
  input  cpuPkg::regId rs2,
  input  cpuPkg::regId rd,
  input  cpuPkg::aluOp aluSel,
  input  logic useImm,
  input  logic regWen,
  input  logic memWen,
  input  logic isLoad,
  input  logic isBranch,
  input  logic isJal,
  input  logic isJalr,
  input  logic isLink,
  input  logic halt,
  input  logic illegal,
  writebackIf.sink   wb,
  exResultIf.producer res,
  output logic redirect,
  output cpuPkg::word target
);

  cpuPkg::word opA;
  cpuPkg::word opB;
  cpuPkg::word aluB;
  cpuPkg::word aluResult;
  logic taken;

  function automatic cpuPkg::word forward(cpuPkg::regId idx, cpuPkg::word regVal);
    return (wb.regWen && wb.rd == idx) ? wb.wdata : regVal;
  endfunction

  always_comb begin
    opA = forward(rs1, rdata1);
    opB = forward(rs2, rdata2);
  end

  assign aluB = useImm ? imm : opB;

  always_comb begin
    unique case (aluSel)
      cpuPkg::aluAdd:   aluResult = opA + aluB;
      cpuPkg::aluSub:   aluResult = opA - aluB;
      cpuPkg::aluAnd:   aluResult = opA & aluB;
      cpuPkg::aluOr:    aluResult = opA | aluB;
      cpuPkg::aluXor:   aluResult = opA ^ aluB;
      cpuPkg::aluSlt:   aluResult = {31'b0, $signed(opA) < $signed(aluB)};
      cpuPkg::aluPassB: aluResult = aluB;
      cpuPkg::aluEq:    aluResult = {31'b0, opA == aluB};
      cpuPkg::aluNe:    aluResult = {31'b0, opA != aluB};
      default:          aluResult = '0;
    endcase
  end

  // jalr target drops bit 0 of the sum
  assign taken    = isBranch & aluResult[0];
  assign target   = isJalr ? {aluResult[31:1], 1'b0} : pc + imm;
  assign redirect = valid & (isJal | isJalr | taken);

  assign res.valid     = valid;
  assign res.rd        = rd;
  assign res.regWen    = valid & regWen;
  assign res.memWen    = valid & memWen;
  assign res.isLoad    = isLoad;
  assign res.isLink    = isLink;
  assign res.halt      = valid & halt;
  assign res.illegal   = valid & illegal;
  assign res.aluResult = aluResult;
  assign res.storeData = opB;
  assign res.linkAddr  = pc + 32'd4;
  assign res.pc        = pc;

endmodule

// File: verilog/memStage.sv
/* Memory and writeback stage. Word accesses only, indexed by address bits
   9:2; upper address bits wrap and the low two bits are ignored. */
module memStage (
  input  logic clk,
  input  logic rstN,
  exResultIf.consumer res,
  writebackIf.source  wb
);

  logic validQ;
  logic regWenQ;
  logic memWenQ;
  logic haltQ;
  logic illegalQ;
  logic isLoadQ;
  logic isLinkQ;
  cpuPkg::regId rdQ;
  cpuPkg::word aluResultQ;
  cpuPkg::word storeDataQ;
  cpuPkg::word linkAddrQ;
  cpuPkg::word pcQ;
  cpuPkg::word loadData;
  logic [cpuPkg::dmemIdxW-1:0] memIdx;

  cpuPkg::word dmem [cpuPkg::dmemWords];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      {validQ, regWenQ, memWenQ, haltQ, illegalQ} <= '0;
    end else begin
      validQ   <= res.valid;
      regWenQ  <= res.regWen;
      memWenQ  <= res.memWen;
      haltQ    <= res.halt;
      illegalQ <= res.illegal;
    end
  end

  always_ff @(posedge clk) begin
    isLoadQ    <= res.isLoad;
    isLinkQ    <= res.isLink;
    rdQ        <= res.rd;
    aluResultQ <= res.aluResult;
    storeDataQ <= res.storeData;
    linkAddrQ  <= res.linkAddr;
    pcQ        <= res.pc;
  end

  assign memIdx   = aluResultQ[cpuPkg::dmemIdxW+1:2];
  assign loadData = dmem[memIdx];

  always_ff @(posedge clk) begin
    if (memWenQ) dmem[memIdx] <= storeDataQ;
  end

  assign wb.retire  = validQ;
  assign wb.regWen  = regWenQ;
  assign wb.rd      = rdQ;
  assign wb.wdata   = isLoadQ ? loadData : (isLinkQ ? linkAddrQ : aluResultQ);
  assign wb.pc      = pcQ;
  assign wb.halt    = haltQ;
  assign wb.illegal = illegalQ;

endmodule

// File: verilog/cpuTop.sv
/* Four-stage RV32I core without stalls. Instruction memory is external and
   read combinationally; halted and illegal stay high until the next reset. */
module cpuTop (
  input  logic clk,
  input  logic rstN,
  output cpuPkg::word     imemAddr,
  input  cpuPkg::instWord imemData,
  output logic retireValid,
  output cpuPkg::word  retirePc,
  output logic retireWen,
  output cpuPkg::regId retireRd,
  output cpuPkg::word  retireData,
  output logic halted,
  output logic illegal
);

  cpuPkg::word pc;
  cpuPkg::word pcNext;
  cpuPkg::word target;
  cpuPkg::word ifIdPc;
  cpuPkg::instWord ifIdInst;
  cpuPkg::word dImm;
  cpuPkg::word rdata1;
  cpuPkg::word rdata2;
  cpuPkg::regId dRd;
  cpuPkg::regId dRs1;
  cpuPkg::regId dRs2;
  cpuPkg::aluOp dAlu;
  logic [9:0] dCtl;
  logic ifIdValid;
  logic redirect;
  logic stopped;
  logic stopNow;
  logic squash;
  logic haltRetire;
  logic haltedQ;
  logic illegalQ;

  // decode/execute register
  logic idExValid;
  cpuPkg::word idExPc;
  cpuPkg::word idExImm;
  cpuPkg::word idExRdata1;
  cpuPkg::word idExRdata2;
  cpuPkg::regId idExRs1;
  cpuPkg::regId idExRs2;
  cpuPkg::regId idExRd;
  cpuPkg::aluOp idExAlu;
  logic [9:0] idExCtl;

  exResultIf exRes ();
  writebackIf wbBus ();

  // ctl bits from msb are useImm regWen memWen isLoad isBranch isJal isJalr isLink halt illegal
  decoder uDecoder (
    .inst (ifIdInst), .rd (dRd), .rs1 (dRs1), .rs2 (dRs2), .imm (dImm), .aluSel (dAlu),
    .useImm (dCtl[9]), .regWen (dCtl[8]), .memWen (dCtl[7]), .isLoad (dCtl[6]),
    .isBranch (dCtl[5]), .isJal (dCtl[4]), .isJalr (dCtl[3]), .isLink (dCtl[2]),
    .halt (dCtl[1]), .illegal (dCtl[0])
  );

  regFile uRegFile (
    .clk (clk), .rs1 (dRs1), .rs2 (dRs2), .rdata1 (rdata1), .rdata2 (rdata2), .wb (wbBus)
  );

  executeUnit uExecute (
    .valid (idExValid), .pc (idExPc), .imm (idExImm), .rdata1 (idExRdata1),
    .rdata2 (idExRdata2), .rs1 (idExRs1), .rs2 (idExRs2), .rd (idExRd), .aluSel (idExAlu),
    .useImm (idExCtl[9]), .regWen (idExCtl[8]), .memWen (idExCtl[7]), .isLoad (idExCtl[6]),
    .isBranch (idExCtl[5]), .isJal (idExCtl[4]), .isJalr (idExCtl[3]),
    .isLink (idExCtl[2]), .halt (idExCtl[1]), .illegal (idExCtl[0]),
    .wb (wbBus), .res (exRes), .redirect (redirect), .target (target)
  );

  memStage uMemStage (.clk (clk), .rstN (rstN), .res (exRes), .wb (wbBus));

  // a redirect or a halt in execute flushes the two younger stages and a halt freezes fetch
  assign stopNow = exRes.halt;
  assign squash  = redirect | stopNow;
  assign pcNext  = (stopped | stopNow) ? pc : (redirect ? target : pc + 32'd4);
  assign imemAddr = pc;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= cpuPkg::resetPc;
      {stopped, ifIdValid, idExValid, haltedQ, illegalQ} <= '0;
    end else begin
      pc        <= pcNext;
      ifIdValid <= ~(squash | stopped);
      idExValid <= ifIdValid & ~squash;
      if (stopNow) stopped <= 1'b1;
      if (haltRetire) begin
        haltedQ  <= 1'b1;
        illegalQ <= wbBus.illegal;
      end
    end
  end

  always_ff @(posedge clk) begin
    ifIdPc     <= pc;
    ifIdInst   <= imemData;
    idExPc     <= ifIdPc;
    idExImm    <= dImm;
    idExRdata1 <= rdata1;
    idExRdata2 <= rdata2;
    idExRs1    <= dRs1;
    idExRs2    <= dRs2;
    idExRd     <= dRd;
    idExAlu    <= dAlu;
    idExCtl    <= dCtl;
  end

  assign haltRetire  = wbBus.retire & wbBus.halt;
  assign retireValid = wbBus.retire;
  assign retirePc    = wbBus.pc;
  assign retireWen   = wbBus.regWen;
  assign retireRd    = wbBus.rd;
  assign retireData  = wbBus.wdata;
  assign halted      = haltedQ | haltRetire;
  assign illegal     = illegalQ | (haltRetire & wbBus.illegal);

endmodule

// File: verif/cpuTb.sv
/* Testbench for cpuTop with generated programs and an ISA model. Registers keep their
   values across resets, so only the first program writes all of them. */
module cpuTb;

  localparam cpuPkg::instWord ebreakInst = 32'h0010_0073;

  logic clk;
  logic rstN;
  cpuPkg::word     imemAddr;
  cpuPkg::instWord imemData;
  logic retireValid;
  cpuPkg::word  retirePc;
  logic retireWen;
  cpuPkg::regId retireRd;
  cpuPkg::word  retireData;
  logic halted;
  logic illegal;

  cpuPkg::instWord imem [256];
  cpuPkg::word modelRegs [32];
  cpuPkg::word modelMem [256];
  cpuPkg::word modelPc;
  integer seed = 32'h6bf1ebe3;
  int progLen;
  int errors = 0;
  int retired = 0;
  int cycles = 0;
  int limit = 0;
  logic sawHalt = 1'b0;

  cpuTop uut (
    .clk (clk), .rstN (rstN), .imemAddr (imemAddr), .imemData (imemData),
    .retireValid (retireValid), .retirePc (retirePc), .retireWen (retireWen),
    .retireRd (retireRd), .retireData (retireData), .halted (halted), .illegal (illegal)
  );

  // instruction memory read combinationally
  assign imemData = imem[imemAddr[9:2]];

  always #5 clk = ~clk;

  function automatic cpuPkg::instWord encR(logic [6:0] f7, cpuPkg::regId rs2,
                                           cpuPkg::regId rs1, logic [2:0] f3,
                                           cpuPkg::regId rd);
    return {f7, rs2, rs1, f3, rd, cpuPkg::opOp};
  endfunction

  function automatic cpuPkg::instWord encI(logic [11:0] imm, cpuPkg::regId rs1,
                                           logic [2:0] f3, cpuPkg::regId rd,
                                           logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic cpuPkg::instWord encS(logic [11:0] imm, cpuPkg::regId rs2,
                                           cpuPkg::regId rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpuPkg::opStore};
  endfunction

  function automatic cpuPkg::instWord encB(logic [12:0] off, cpuPkg::regId rs2,
                                           cpuPkg::regId rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpuPkg::opBranch};
  endfunction

  function automatic cpuPkg::instWord encJ(logic [20:0] off, cpuPkg::regId rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, cpuPkg::opJal};
  endfunction

  function automatic cpuPkg::regId pickReg();
    cpuPkg::regId r;
    r = 5'($random(seed));
    return (r == 5'd0) ? 5'd1 : r;
  endfunction

  task automatic emit(input cpuPkg::instWord inst);
    imem[progLen] = inst;
    progLen++;
  endtask

  task automatic checkValue(input string name, input cpuPkg::word actual,
                            input cpuPkg::word expected);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  // executes one instruction of the program on the model state
  function automatic void isaStep(output cpuPkg::word ePc, output logic eWen,
                                  output cpuPkg::regId eRd, output cpuPkg::word eData,
                                  output logic eHalt, output logic eIll);
    cpuPkg::instWord inst;
    cpuPkg::word a;
    cpuPkg::word b;
    cpuPkg::word immI;
    cpuPkg::word immS;
    cpuPkg::word immB;
    cpuPkg::word immJ;
    cpuPkg::word addr;
    cpuPkg::word next;
    cpuPkg::word data;
    logic wen;
    logic bad;
    inst = imem[modelPc[9:2]];
    a = modelRegs[inst[19:15]];
    b = modelRegs[inst[24:20]];
    immI = {{20{inst[31]}}, inst[31:20]};
    immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    next = modelPc + 32'd4;
    data = '0;
    wen = 1'b0;
    bad = 1'b0;
    eHalt = 1'b0;
    case (inst[6:0])
      cpuPkg::opOp: begin
        wen = 1'b1;
        // funct7 and funct3 together
        case ({inst[31:25], inst[14:12]})
          10'h000: data = a + b;
          10'h100: data = a - b;
          10'h002: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          10'h004: data = a ^ b;
          10'h006: data = a | b;
          10'h007: data = a & b;
          default: bad = 1'b1;
        endcase
      end
      cpuPkg::opImm: {wen, bad, data} = {1'b1, inst[14:12] != 3'b000, a + immI};
      cpuPkg::opLui: {wen, data} = {1'b1, inst[31:12], 12'b0};
      cpuPkg::opLoad: begin
        addr = a + immI;
        {wen, bad, data} = {1'b1, inst[14:12] != 3'b010, modelMem[addr[9:2]]};
      end
      cpuPkg::opStore: begin
        addr = a + immS;
        if (inst[14:12] == 3'b010) modelMem[addr[9:2]] = b;
        else bad = 1'b1;
      end
      cpuPkg::opBranch: begin
        if (inst[14:12] == 3'b000 && a == b) next = modelPc + immB;
        else if (inst[14:12] == 3'b001 && a != b) next = modelPc + immB;
        else if (inst[14:12] > 3'b001) bad = 1'b1;
      end
      cpuPkg::opJal: {wen, data, next} = {1'b1, modelPc + 32'd4, modelPc + immJ};
      cpuPkg::opJalr: begin
        {wen, data, next} = {1'b1, modelPc + 32'd4, (a + immI) & ~32'd1};
        bad = (inst[14:12] != 3'b000);
      end
      default: begin
        if (inst == ebreakInst) eHalt = 1'b1;
        else bad = 1'b1;
      end
    endcase
    if (bad) {wen, eHalt} = 2'b01;
    ePc = modelPc;
    eWen = wen && inst[11:7] != 5'd0;
    eRd = inst[11:7];
    eData = data;
    eIll = bad;
    if (eWen) modelRegs[inst[11:7]] = data;
    modelPc = next;
  endfunction

  task automatic clearProgram();
    // unused words hold an illegal opcode
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[7:0], ~i[7:0], 16'h007f};
    end
    progLen = 0;
  endtask

  // random register setup followed by dependent ALU chains
  task automatic buildAluProgram();
    cpuPkg::regId prev;
    cpuPkg::regId cur;
    cpuPkg::regId other;
    logic [2:0] kind;
    for (int r = 1; r < 32; r++) begin
      emit({20'($random(seed)), 5'(r), cpuPkg::opLui});
      emit(encI(12'($random(seed)), 5'(r), 3'b000, 5'(r), cpuPkg::opImm));
    end
    prev = pickReg();
    for (int k = 0; k < 24; k++) begin
      cur = pickReg();
      other = pickReg();
      kind = 3'($random(seed));
      case (kind)
        3'd0: emit(encR(7'h00, other, prev, 3'b000, cur));
        3'd1: emit(encR(7'h20, other, prev, 3'b000, cur));
        3'd2: emit(encR(7'h00, other, prev, 3'b111, cur));
        3'd3: emit(encR(7'h00, other, prev, 3'b110, cur));
        3'd4: emit(encR(7'h00, other, prev, 3'b100, cur));
        3'd5: emit(encR(7'h00, other, prev, 3'b010, cur));
        default: emit(encI(12'($random(seed)), prev, 3'b000, cur, cpuPkg::opImm));
      endcase
      prev = cur;
    end
    // writes to x0 are dropped and reads of x0 give zero
    emit(encI(12'h123, prev, 3'b000, 5'd0, cpuPkg::opImm));
    emit(encR(7'h00, prev, prev, 3'b000, 5'd0));
    emit(encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd12));
    emit(encI(12'h000, 5'd0, 3'b000, 5'd13, cpuPkg::opImm));
    emit(ebreakInst);
  endtask

  task automatic buildMemProgram();
    logic [7:0] slot [8];
    cpuPkg::regId dst;
    for (int k = 0; k < 8; k++) begin
      slot[k] = 8'($random(seed));
      emit(encS({2'b00, slot[k], 2'b00}, pickReg(), 5'd0));
    end
    // each load is used by the very next instruction
    for (int k = 0; k < 8; k++) begin
      dst = pickReg();
      emit(encI({2'b00, slot[7 - k], 2'b00}, 5'd0, 3'b010, dst, cpuPkg::opLoad));
      emit(encR(7'h00, dst, dst, 3'b000, pickReg()));
    end
    emit(encI(12'h100, 5'd0, 3'b000, 5'd20, cpuPkg::opImm));
    emit(encI(12'($random(seed)), 5'd0, 3'b000, 5'd22, cpuPkg::opImm));
    emit(encS(12'd4, 5'd22, 5'd20));
    emit(encI(12'd4, 5'd20, 3'b010, 5'd23, cpuPkg::opLoad));
    emit(encS(12'd12, 5'd23, 5'd20));
    emit(encI(12'd12, 5'd20, 3'b010, 5'd24, cpuPkg::opLoad));
    emit(ebreakInst);
  endtask

  task automatic buildBranchProgram();
    emit(encI(12'd5, 5'd0, 3'b000, 5'd1, cpuPkg::opImm));
    emit(encI(12'd5, 5'd0, 3'b000, 5'd2, cpuPkg::opImm));
    emit(encI(12'd7, 5'd0, 3'b000, 5'd3, cpuPkg::opImm));
    // beq taken, bne not taken, bne taken, beq not taken
    emit(encB(13'd12, 5'd2, 5'd1, 3'b000));
    emit(encI(12'd1, 5'd0, 3'b000, 5'd4, cpuPkg::opImm));
    emit(encI(12'd2, 5'd0, 3'b000, 5'd4, cpuPkg::opImm));
    emit(encB(13'd12, 5'd2, 5'd1, 3'b001));
    emit(encI(12'd3, 5'd0, 3'b000, 5'd5, cpuPkg::opImm));
    emit(encB(13'd12, 5'd3, 5'd1, 3'b001));
    emit(encI(12'd4, 5'd0, 3'b000, 5'd4, cpuPkg::opImm));
    emit(encI(12'd5, 5'd0, 3'b000, 5'd4, cpuPkg::opImm));
    emit(encB(13'd8, 5'd3, 5'd1, 3'b000));
    emit(encI(12'd1, 5'd1, 3'b000, 5'd7, cpuPkg::opImm));
    for (int k = 0; k < 6; k++) begin
      emit(encB(13'd12, pickReg(), pickReg(), {2'b00, 1'($random(seed))}));
      emit(encI(12'($random(seed)), pickReg(), 3'b000, pickReg(), cpuPkg::opImm));
      emit(encI(12'($random(seed)), pickReg(), 3'b000, pickReg(), cpuPkg::opImm));
    end
    emit(encJ(21'd12, 5'd8));
    emit(encI(12'd6, 5'd0, 3'b000, 5'd4, cpuPkg::opImm));
    emit(encI(12'd7, 5'd0, 3'b000, 5'd4, cpuPkg::opImm));
    // odd jalr target whose bit 0 must be dropped
    emit(encI(12'((progLen + 4) * 4 + 1), 5'd0, 3'b000, 5'd9, cpuPkg::opImm));
    emit(encI(12'd0, 5'd9, 3'b000, 5'd10, cpuPkg::opJalr));
    emit(encI(12'd8, 5'd0, 3'b000, 5'd4, cpuPkg::opImm));
    emit(encI(12'd9, 5'd0, 3'b000, 5'd4, cpuPkg::opImm));
    emit(encR(7'h00, 5'd10, 5'd8, 3'b000, 5'd11));
    emit(ebreakInst);
  endtask

  task automatic buildIllegalProgram();
    emit(encI(12'd1, 5'd0, 3'b000, 5'd1, cpuPkg::opImm));
    emit(encR(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
    // mul is outside the subset
    emit(encR(7'h01, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(encI(12'd9, 5'd0, 3'b000, 5'd3, cpuPkg::opImm));
    emit(encI(12'd9, 5'd0, 3'b000, 5'd4, cpuPkg::opImm));
    emit(ebreakInst);
  endtask

  task automatic runProgram();
    limit += 4 * progLen + 20;
    @(posedge clk);
    rstN <= 1'b0;
    repeat (8) @(posedge clk);
    modelPc = cpuPkg::resetPc;
    sawHalt = 1'b0;
    rstN <= 1'b1;
    while (halted !== 1'b1) @(posedge clk);
    // window for a stray retire after the halt
    repeat (4) @(posedge clk);
  endtask

  always @(posedge clk) begin : compareRetire
    cpuPkg::word expPc;
    cpuPkg::word expData;
    cpuPkg::regId expRd;
    logic expWen;
    logic expHalt;
    logic expIll;
    if (rstN && retireValid === 1'b1) begin
      if (sawHalt) begin
        errors++;
        $display("instruction at pc %h retired after the core halted", retirePc);
      end else begin
        isaStep(expPc, expWen, expRd, expData, expHalt, expIll);
        retired++;
        checkValue("retirePc", retirePc, expPc);
        checkValue("retireWen", 32'(retireWen), 32'(expWen));
        if (expWen) begin
          checkValue("retireRd", 32'(retireRd), 32'(expRd));
          checkValue("retireData", retireData, expData);
        end
        if (expHalt) begin
          checkValue("illegal", 32'(illegal), 32'(expIll));
          sawHalt = 1'b1;
          if (halted !== 1'b1) begin
            errors++;
            $display("the core did not halt at pc %h", retirePc);
          end
        end else if (halted !== 1'b0) begin
          errors++;
          $display("the core halted at pc %h, which holds no stop instruction", retirePc);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the core never halted", cycles);
      $display("%0d errors, %0d instructions retired", errors, retired);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    modelRegs[0] = '0;
    clearProgram();
    buildAluProgram();
    runProgram();
    clearProgram();
    buildMemProgram();
    runProgram();
    clearProgram();
    buildBranchProgram();
    runProgram();
    clearProgram();
    buildIllegalProgram();
    runProgram();
    $display("%0d errors, %0d instructions retired", errors, retired);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: build.f
verilog/cpuPkg.sv
verilog/pipeBus.sv
verilog/decoder.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/memStage.sv
verilog/cpuTop.sv
verif/cpuTb.sv

// File: Bender.yml
package:
  name: rv32i_pipe

sources:
  - verilog/cpuPkg.sv
  - verilog/pipeBus.sv
  - verilog/decoder.sv
  - verilog/regFile.sv
  - verilog/executeUnit.sv
  - verilog/memStage.sv
  - verilog/cpuTop.sv
  - target: test
    files:
      - verif/cpuTb.sv
